/* include/fetch_config.svh */
// sizing macros for the instruction fetch front end
// reset PC, queue depth and BTB size

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// --------------------
// reset vector
// --------------------
// boot ROM entry in kseg1
`define FETCH_START_PC 32'hBFC0_0000

// --------------------
// storage sizes
// --------------------
// fetch blocks held between fetch and decode
`define FETCH_QUEUE_DEPTH 4

// log2 of the number of BTB entries
`define BTB_INDEX_BITS 4

`endif

/* logic/fetchPkg.sv */
// shared fetch types
// exception code and the fetch block carried through the queue

package fetchPkg;

    // --------------------
    // exception codes
    // --------------------
    // subset of the CP0 cause encodings
    typedef enum logic [4:0] {
        // no exception on this block
        EXC_NONE = 5'd0,
        // address error on instruction fetch
        EXC_ADEL = 5'd4
    } excCode_t;

    // --------------------
    // fetch block
    // --------------------
    // one queue entry, four instruction slots
    typedef struct packed {
        // word address of the first wanted slot
        logic [31:0]  pc;
        // bit i set when slot i is wanted
        logic [3:0]   enable;
        // block only exists to pick up a delay slot
        logic         delaySlot;
        logic         hasExc;
        excCode_t     excCode;
        // slot i lives in bits 32i+31 down to 32i
        logic [127:0] data;
    } fetchBlock_t;

endpackage

/* logic/fetchPcGen.sv */
// fetch PC register with next-block selection
// slot enable mask and word alignment check

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetchPcGen (
    input  logic                 clk,
    input  logic                 rst,
    // exception redirect
    input  logic                 excValid_i,
    input  logic [31:0]          excPc_i,
    // back-end branch correction
    input  logic                 brFlush_i,
    input  logic [31:0]          brTarget_i,
    // request accepted by the memory
    input  logic                 advance_i,
    // BTB prediction on the current PC
    input  logic                 btbHit_i,
    input  logic [1:0]           btbSlot_i,
    input  logic [31:0]          btbTarget_i,
    output logic [31:0]          fetchPc_o,
    output logic [31:0]          blockBase_o,
    output logic [3:0]           enable_o,
    output logic                 delaySlot_o,
    output logic                 misaligned_o,
    output fetchPkg::excCode_t   excCode_o
);

    // unaligned PC as loaded from a redirect
    logic [31:0] pcReg;
    // branch target held across the delay-slot block
    logic [31:0] pendTarget;
    logic        dsPending;
    logic        predHit;
    logic [3:0]  posMask;
    logic [3:0]  stopMask;
    logic [31:0] seqBase;

    // --------------------
    // slot masks
    // --------------------
    // slots below the PC position are not wanted
    always_comb begin
        case (pcReg[3:2])
            2'd0:    posMask = 4'b1111;
            2'd1:    posMask = 4'b1110;
            2'd2:    posMask = 4'b1100;
            default: posMask = 4'b1000;
        endcase
    end

    // keep the branch and its delay slot, drop the rest
    always_comb begin
        case (btbSlot_i)
            2'd0:    stopMask = 4'b0011;
            2'd1:    stopMask = 4'b0111;
            default: stopMask = 4'b1111;
        endcase
    end

    // prediction is ignored on the delay-slot block
    assign predHit = btbHit_i && !dsPending;
    assign seqBase = {blockBase_o[31:4] + 28'd1, 4'b0000};

    // --------------------
    // PC register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            pcReg     <= `FETCH_START_PC;
            dsPending <= 1'b0;
        end else if (excValid_i || brFlush_i) begin
            // exception outranks the branch correction
            pcReg     <= excValid_i ? excPc_i : brTarget_i;
            dsPending <= 1'b0;
        end else if (advance_i) begin
            if (dsPending) begin
                // delay slot fetched, now take the branch
                pcReg     <= pendTarget;
                dsPending <= 1'b0;
            end else if (predHit && btbSlot_i != 2'd3) begin
                pcReg <= btbTarget_i;
            end else if (predHit) begin
                // branch in slot 3, delay slot sits in the next block
                pcReg     <= seqBase;
                dsPending <= 1'b1;
            end else begin
                pcReg <= seqBase;
            end
        end
    end

    // target only matters while dsPending is set
    always_ff @(posedge clk) begin
        if (advance_i && predHit && btbSlot_i == 2'd3) begin
            pendTarget <= btbTarget_i;
        end
    end

    // --------------------
    // outputs
    // --------------------
    assign fetchPc_o    = pcReg;
    assign blockBase_o  = {pcReg[31:4], 4'b0000};
    assign delaySlot_o  = dsPending;
    assign enable_o     = dsPending ? 4'b0001 : (predHit ? (posMask & stopMask) : posMask);
    assign misaligned_o = |pcReg[1:0];
    assign excCode_o    = misaligned_o ? fetchPkg::EXC_ADEL : fetchPkg::EXC_NONE;

endmodule

/* logic/branchTargetBuffer.sv */
// direct-mapped branch target buffer
// combinational lookup on the fetch PC, registered update

`timescale 1ns/100ps
`include "fetch_config.svh"

module branchTargetBuffer (
    input  logic        clk,
    input  logic        rst,
    // lookup on the current fetch PC
    input  logic [31:0] lookupPc_i,
    // update from the back end
    input  logic        updValid_i,
    input  logic [31:0] updPc_i,
    input  logic [31:0] updTarget_i,
    output logic        hit_o,
    output logic [1:0]  slot_o,
    output logic [31:0] target_o
);

    // --------------------
    // geometry
    // --------------------
    localparam int IDX_W   = `BTB_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;
    // index starts above the 16-byte block offset
    localparam int TAG_LSB = 4 + IDX_W;
    localparam int TAG_W   = 32 - TAG_LSB;

    logic [ENTRIES-1:0] entValid;
    logic [TAG_W-1:0]   entTag    [ENTRIES];
    logic [1:0]         entSlot   [ENTRIES];
    logic [31:0]        entTarget [ENTRIES];

    logic [IDX_W-1:0]   lookIdx;
    logic [TAG_W-1:0]   lookTag;
    logic [IDX_W-1:0]   updIdx;
    logic               tagMatch;
    logic               slotAhead;

    assign lookIdx = lookupPc_i[TAG_LSB-1:4];
    assign lookTag = lookupPc_i[31:TAG_LSB];
    assign updIdx  = updPc_i[TAG_LSB-1:4];

    // --------------------
    // lookup
    // --------------------
    assign tagMatch  = entTag[lookIdx] == lookTag;
    // a branch behind the entry point is never reached
    assign slotAhead = entSlot[lookIdx] >= lookupPc_i[3:2];

    assign hit_o    = entValid[lookIdx] && tagMatch && slotAhead;
    assign slot_o   = entSlot[lookIdx];
    assign target_o = entTarget[lookIdx];

    // --------------------
    // update
    // --------------------
    // valid bits, the only state cleared by reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            entValid <= '0;
        end else if (updValid_i) begin
            entValid[updIdx] <= 1'b1;
        end
    end

    // entry fields, overwritten on every update
    always_ff @(posedge clk) begin
        if (updValid_i) begin
            entTag[updIdx]    <= updPc_i[31:TAG_LSB];
            // slot of the branch inside its block
            entSlot[updIdx]   <= updPc_i[3:2];
            entTarget[updIdx] <= updTarget_i;
        end
    end

endmodule

/* logic/fetchQueue.sv */
// circular FIFO of fetch blocks
// flush, free-slot count and valid/ready drain to decode

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetchQueue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush_i,
    // block coming back from memory
    input  logic                                pushValid_i,
    input  fetchPkg::fetchBlock_t               pushBlock_i,
    output logic [$clog2(`FETCH_QUEUE_DEPTH):0] count_o,
    // drain side to decode
    output logic                                outValid_o,
    output fetchPkg::fetchBlock_t               outBlock_o,
    input  logic                                outReady_i
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    fetchPkg::fetchBlock_t entries [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             doPush;
    logic             doPop;

    // --------------------
    // handshakes
    // --------------------
    assign full   = count == CNT_W'(DEPTH);
    assign doPop  = outValid_o && outReady_i;
    // a full queue still takes a push when the head leaves
    assign doPush = pushValid_i && (!full || doPop);

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (doPush && !flush_i) begin
            entries[wrPtr] <= pushBlock_i;
        end
    end

    assign count_o    = count;
    assign outValid_o = count != '0;
    // head holds still until popped
    assign outBlock_o = entries[rdPtr];

endmodule

/* logic/fetchControl.sv */
// fetch control FSM
// request issue, stale response drop, exception push and halt

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetchControl (
    input  logic                                clk,
    input  logic                                rst,
    // exception or branch flush this cycle
    input  logic                                redirect_i,
    // current fetch PC state
    input  logic                                misaligned_i,
    input  logic [31:0]                         pc_i,
    input  logic [3:0]                          enable_i,
    input  logic                                delaySlot_i,
    input  fetchPkg::excCode_t                  excCode_i,
    input  logic [$clog2(`FETCH_QUEUE_DEPTH):0] queueCount_i,
    // memory request
    output logic                                icReqValid_o,
    input  logic                                icReqReady_i,
    // memory response
    input  logic                                icRespValid_i,
    input  logic [127:0]                        icRespData_i,
    output logic                                advance_o,
    output logic                                pushValid_o,
    output fetchPkg::fetchBlock_t               pushBlock_o,
    output logic                                queueFlush_o
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic             outstanding;
    // response still owed to a request from before a redirect
    logic             dropResp;
    logic             halted;
    logic [31:0]      flightPc;
    logic [3:0]       flightEnable;
    logic             flightDs;
    logic             spaceOk;
    logic             reqFire;
    logic             respPush;
    logic             excPush;

    // --------------------
    // issue gating
    // --------------------
    // issue waits for the in-flight request, so its slot is already back in the count
    assign spaceOk   = queueCount_i < CNT_W'(DEPTH);

    assign icReqValid_o = !outstanding && !halted && !redirect_i && !misaligned_i && spaceOk;
    assign reqFire      = icReqValid_o && icReqReady_i;
    assign advance_o    = reqFire;

    // misaligned PC turns into an exception entry, no memory access
    assign excPush  = !outstanding && !halted && !redirect_i && misaligned_i && spaceOk;
    // only answers we are still waiting for get queued
    assign respPush = icRespValid_i && outstanding && !dropResp && !redirect_i;

    assign pushValid_o  = respPush || excPush;
    assign queueFlush_o = redirect_i;

    // --------------------
    // control state
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            outstanding <= 1'b0;
            dropResp    <= 1'b0;
            halted      <= 1'b0;
        end else begin
            if (icRespValid_i && outstanding) begin
                outstanding <= 1'b0;
                dropResp    <= 1'b0;
            end else if (reqFire) begin
                outstanding <= 1'b1;
            end
            if (redirect_i) begin
                // redirect restarts fetch
                halted <= 1'b0;
                if (outstanding && !icRespValid_i) begin
                    dropResp <= 1'b1;
                end
            end else if (excPush) begin
                halted <= 1'b1;
            end
        end
    end

    // snapshot of the block that was requested
    always_ff @(posedge clk) begin
        if (reqFire) begin
            flightPc     <= pc_i;
            flightEnable <= enable_i;
            flightDs     <= delaySlot_i;
        end
    end

    // --------------------
    // pushed block
    // --------------------
    always_comb begin
        if (excPush) begin
            pushBlock_o.pc        = pc_i;
            pushBlock_o.enable    = enable_i;
            pushBlock_o.delaySlot = delaySlot_i;
            pushBlock_o.hasExc    = 1'b1;
            pushBlock_o.excCode   = excCode_i;
            pushBlock_o.data      = '0;
        end else begin
            pushBlock_o.pc        = flightPc;
            pushBlock_o.enable    = flightEnable;
            pushBlock_o.delaySlot = flightDs;
            pushBlock_o.hasExc    = 1'b0;
            pushBlock_o.excCode   = fetchPkg::EXC_NONE;
            pushBlock_o.data      = icRespData_i;
        end
    end

endmodule

/* logic/fetchUnit.sv */
// fetch front end top level
// PC generator, BTB, fetch queue and control

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  rst,
    // redirects from the back end
    input  logic                  excValid_i,
    input  logic [31:0]           excPc_i,
    input  logic                  brFlush_i,
    input  logic [31:0]           brTarget_i,
    // BTB training
    input  logic                  btbUpdValid_i,
    input  logic [31:0]           btbUpdPc_i,
    input  logic [31:0]           btbUpdTarget_i,
    // instruction memory
    output logic                  icReqValid_o,
    output logic [31:0]           icReqAddr_o,
    input  logic                  icReqReady_i,
    input  logic                  icRespValid_i,
    input  logic [127:0]          icRespData_i,
    // decode side
    output logic                  outValid_o,
    output fetchPkg::fetchBlock_t outBlock_o,
    input  logic                  outReady_i
);

    logic                                redirect;
    logic                                advance;
    logic                                btbHit;
    logic [1:0]                          btbSlot;
    logic [31:0]                         btbTarget;
    logic [31:0]                         fetchPc;
    logic [3:0]                          enable;
    logic                                delaySlot;
    logic                                misaligned;
    fetchPkg::excCode_t                  excCode;
    logic                                pushValid;
    fetchPkg::fetchBlock_t               pushBlock;
    logic                                queueFlush;
    logic [$clog2(`FETCH_QUEUE_DEPTH):0] queueCount;

    // either redirect source restarts the front end
    assign redirect = excValid_i || brFlush_i;

    // --------------------
    // datapath
    // --------------------
    fetchPcGen u_fetchPcGen (
        .clk(clk), .rst(rst),
        .excValid_i(excValid_i), .excPc_i(excPc_i),
        .brFlush_i(brFlush_i), .brTarget_i(brTarget_i),
        .advance_i(advance),
        .btbHit_i(btbHit), .btbSlot_i(btbSlot), .btbTarget_i(btbTarget),
        .fetchPc_o(fetchPc), .blockBase_o(icReqAddr_o), .enable_o(enable),
        .delaySlot_o(delaySlot), .misaligned_o(misaligned), .excCode_o(excCode)
    );

    branchTargetBuffer u_branchTargetBuffer (
        .clk(clk), .rst(rst),
        .lookupPc_i(fetchPc),
        .updValid_i(btbUpdValid_i), .updPc_i(btbUpdPc_i), .updTarget_i(btbUpdTarget_i),
        .hit_o(btbHit), .slot_o(btbSlot), .target_o(btbTarget)
    );

    fetchQueue u_fetchQueue (
        .clk(clk), .rst(rst), .flush_i(queueFlush),
        .pushValid_i(pushValid), .pushBlock_i(pushBlock),
        .count_o(queueCount),
        .outValid_o(outValid_o), .outBlock_o(outBlock_o), .outReady_i(outReady_i)
    );

    // --------------------
    // control
    // --------------------
    fetchControl u_fetchControl (
        .clk(clk), .rst(rst),
        .redirect_i(redirect),
        .misaligned_i(misaligned), .pc_i(fetchPc), .enable_i(enable),
        .delaySlot_i(delaySlot), .excCode_i(excCode),
        .queueCount_i(queueCount),
        .icReqValid_o(icReqValid_o), .icReqReady_i(icReqReady_i),
        .icRespValid_i(icRespValid_i), .icRespData_i(icRespData_i),
        .advance_o(advance), .pushValid_o(pushValid), .pushBlock_o(pushBlock),
        .queueFlush_o(queueFlush)
    );

endmodule

/* sim/fetchTests.svh */
// directed fetch tests and their stimulus helpers
// included into the testbench module

// --------------------
// stimulus helpers
// --------------------
// one-cycle redirect, later blocks are counted from here
task automatic driveRedirect(input logic excV, input logic [31:0] excTarget,
                             input logic brV, input logic [31:0] brTarget_);
    @(negedge clk);
    excValid = excV;
    excPc    = excTarget;
    brFlush  = brV;
    brTarget = brTarget_;
    gotBase  = gotQ.size();
    accBase  = accCount;
    reqBase  = reqCycles;
    @(negedge clk);
    excValid = 1'b0;
    brFlush  = 1'b0;
endtask

// one BTB write for a branch at pc
task automatic trainBtb(input logic [31:0] pc, input logic [31:0] target);
    @(negedge clk);
    btbUpdValid  = 1'b1;
    btbUpdPc     = pc;
    btbUpdTarget = target;
    @(negedge clk);
    btbUpdValid  = 1'b0;
endtask

// n blocks in address order, first one cut at its slot position
task automatic expectSequential(input logic [31:0] pc, input int n);
    logic [31:0] addr;
    addr = pc;
    for (int i = 0; i < n; i++) begin
        expQ.push_back(makeBlock(addr, 4'b1111 << addr[3:2], 1'b0));
        addr = {addr[31:4], 4'b0000} + 32'd16;
    end
endtask

// waits for as many blocks as expected, then checks them in order
task automatic compareExpected(input string name);
    int waited;
    waited = 0;
    while (gotQ.size() - gotBase < expQ.size() && waited < 30 * expQ.size()) begin
        @(negedge clk);
        waited++;
    end
    if (gotQ.size() - gotBase < expQ.size()) begin
        $display("%s: only %0d of %0d blocks reached decode in time", name,
                 gotQ.size() - gotBase, expQ.size());
        otherCount++;
    end else begin
        foreach (expQ[i]) begin
            checkBlock(gotQ[gotBase + i], expQ[i], $sformatf("%s[%0d]", name, i));
        end
    end
    expQ.delete();
endtask

// --------------------
// directed tests
// --------------------
task automatic sequentialFromReset();
    expectSequential(`FETCH_START_PC, 6);
    compareExpected("reset");
endtask

// branch at slot 1 keeps slots up to its delay slot
task automatic branchInSlotOne();
    trainBtb(32'h0000_1004, 32'h0000_2000);
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_1000);
    expQ.push_back(makeBlock(32'h0000_1000, 4'b0111, 1'b0));
    expectSequential(32'h0000_2000, 2);
    compareExpected("slot1");
    // entry at slot 1 clears slot 0 as well
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_1004);
    expQ.push_back(makeBlock(32'h0000_1004, 4'b0110, 1'b0));
    expectSequential(32'h0000_2000, 2);
    compareExpected("slot1entry");
endtask

// delay slot fetched alone before the jump
task automatic branchInSlotThree();
    trainBtb(32'h0000_304C, 32'h0000_4000);
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_3040);
    expQ.push_back(makeBlock(32'h0000_3040, 4'b1111, 1'b0));
    expQ.push_back(makeBlock(32'h0000_3050, 4'b0001, 1'b1));
    expectSequential(32'h0000_4000, 2);
    compareExpected("slot3");
endtask

task automatic excBeatsBranch();
    driveRedirect(1'b1, 32'h0000_5000, 1'b1, 32'h0000_6000);
    expectSequential(32'h0000_5000, 3);
    compareExpected("excwins");
endtask

// AdEL entry, then a halt until the next redirect
task automatic misalignedRedirect();
    fetchPkg::fetchBlock_t blk;
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_7002);
    blk         = makeBlock(32'h0000_7002, 4'b1111, 1'b0);
    blk.hasExc  = 1'b1;
    blk.excCode = fetchPkg::EXC_ADEL;
    blk.data    = '0;
    expQ.push_back(blk);
    compareExpected("adel");
    repeat (20) @(negedge clk);
    if (gotQ.size() - gotBase != 1) begin
        $display("halted front end delivered %0d blocks instead of one",
                 gotQ.size() - gotBase);
        otherCount++;
    end
    if (reqCycles != reqBase) begin
        $display("memory request raised after a misaligned redirect");
        otherCount++;
    end
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_8000);
    expectSequential(32'h0000_8000, 3);
    compareExpected("resume");
endtask

// random stalls on both sides, queue space checked per request
task automatic backPressure();
    readyMode = 1'b1;
    slowMem   = 1'b1;
    driveRedirect(1'b0, '0, 1'b1, 32'h0000_9000);
    checkSpace = 1'b1;
    expectSequential(32'h0000_9000, 12);
    compareExpected("backpressure");
    checkSpace = 1'b0;
    readyMode  = 1'b0;
    slowMem    = 1'b0;
endtask

/* sim/fetchUnit_tb.sv */
// testbench top for the fetch front end
// clock, reset, memory and decode models, compare tasks and watchdog

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetchUnit_tb;

    // blocks checked per test, sets the watchdog budget
    localparam int TEST_BLOCKS     = 6 + 6 + 4 + 3 + 4 + 12;
    localparam int WATCHDOG_CYCLES = TEST_BLOCKS * 20;
    localparam int DEPTH           = `FETCH_QUEUE_DEPTH;

    logic                  clk;
    logic                  rst;
    logic                  excValid;
    logic [31:0]           excPc;
    logic                  brFlush;
    logic [31:0]           brTarget;
    logic                  btbUpdValid;
    logic [31:0]           btbUpdPc;
    logic [31:0]           btbUpdTarget;
    logic                  icReqValid_o;
    logic [31:0]           icReqAddr_o;
    logic                  icReqReady;
    logic                  icRespValid;
    logic [127:0]          icRespData;
    logic                  outValid_o;
    fetchPkg::fetchBlock_t outBlock_o;
    logic                  outReady;

    // memory model state
    integer                seed = 32'ha775_7a5f;
    logic                  memBusy;
    logic [31:0]           memAddr;
    int                    memWait;
    // test mode flags
    logic                  readyMode;
    logic                  slowMem;
    logic                  checkSpace;
    // scoreboard, blocks seen by decode and blocks expected
    fetchPkg::fetchBlock_t gotQ [$];
    fetchPkg::fetchBlock_t expQ [$];
    int                    gotBase;
    int                    accCount;
    int                    accBase;
    int                    reqCycles;
    int                    reqBase;
    int                    mismatchCount;
    int                    otherCount;
    int                    spaceErrors;

    fetchUnit u_fetchUnit (
        .clk(clk), .rst(rst),
        .excValid_i(excValid), .excPc_i(excPc),
        .brFlush_i(brFlush), .brTarget_i(brTarget),
        .btbUpdValid_i(btbUpdValid), .btbUpdPc_i(btbUpdPc), .btbUpdTarget_i(btbUpdTarget),
        .icReqValid_o(icReqValid_o), .icReqAddr_o(icReqAddr_o), .icReqReady_i(icReqReady),
        .icRespValid_i(icRespValid), .icRespData_i(icRespData),
        .outValid_o(outValid_o), .outBlock_o(outBlock_o), .outReady_i(outReady)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // reference rules
    // --------------------
    // memory content for one instruction word
    function automatic logic [31:0] slotData(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    // block as the memory would return it for pc
    function automatic fetchPkg::fetchBlock_t makeBlock(input logic [31:0] pc,
                                                        input logic [3:0] en,
                                                        input logic ds);
        fetchPkg::fetchBlock_t blk;
        logic [31:0]           base;
        base          = {pc[31:4], 4'b0000};
        blk.pc        = pc;
        blk.enable    = en;
        blk.delaySlot = ds;
        blk.hasExc    = 1'b0;
        blk.excCode   = fetchPkg::EXC_NONE;
        for (int i = 0; i < 4; i++) begin
            blk.data[32*i +: 32] = slotData(base + 32'(4 * i));
        end
        return blk;
    endfunction

    // --------------------
    // compare tasks
    // --------------------
    task automatic checkExc(input fetchPkg::excCode_t got, input fetchPkg::excCode_t exp,
                            input string name);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkBlock(input fetchPkg::fetchBlock_t got,
                              input fetchPkg::fetchBlock_t exp, input string name);
        if (got.pc !== exp.pc) begin
            $display("MISMATCH %s.pc got %h expected %h", name, got.pc, exp.pc);
            mismatchCount++;
        end
        if (got.enable !== exp.enable) begin
            $display("MISMATCH %s.enable got %h expected %h", name, got.enable, exp.enable);
            mismatchCount++;
        end
        if (got.delaySlot !== exp.delaySlot) begin
            $display("MISMATCH %s.delaySlot got %h expected %h", name, got.delaySlot,
                     exp.delaySlot);
            mismatchCount++;
        end
        if (got.hasExc !== exp.hasExc) begin
            $display("MISMATCH %s.hasExc got %h expected %h", name, got.hasExc, exp.hasExc);
            mismatchCount++;
        end
        checkExc(got.excCode, exp.excCode, {name, ".excCode"});
        if (got.data !== exp.data) begin
            $display("MISMATCH %s.data got %h expected %h", name, got.data, exp.data);
            mismatchCount++;
        end
    endtask

    // --------------------
    // memory and decode
    // --------------------
    // drives on the falling edge, samples 1 ns later once inputs settled
    initial begin
        icReqReady  = 1'b0;
        icRespValid = 1'b0;
        icRespData  = '0;
        outReady    = 1'b0;
        memBusy     = 1'b0;
        memAddr     = '0;
        memWait     = 0;
        forever begin
            @(negedge clk);
            icRespValid = 1'b0;
            if (memBusy) begin
                if (memWait == 0) begin
                    // response lands at the next rising edge
                    icRespValid = 1'b1;
                    for (int i = 0; i < 4; i++) begin
                        icRespData[32*i +: 32] = slotData(memAddr + 32'(4 * i));
                    end
                    memBusy = 1'b0;
                end else begin
                    memWait--;
                end
            end
            icReqReady = rst && (!readyMode || ($random(seed) & 1) != 0);
            // decode mostly stalls under back-pressure
            outReady   = !readyMode || ($random(seed) & 7) == 0;
            #1;
            // decode drops its input on a redirect
            if (excValid || brFlush) begin
                outReady = 1'b0;
            end
            if (rst && icReqValid_o) begin
                reqCycles++;
            end
            if (rst && icReqValid_o && icReqReady) begin
                // occupancy before this edge, pops at this edge not yet counted
                if (checkSpace && (accCount - accBase) - (gotQ.size() - gotBase) >= DEPTH) begin
                    $display("memory request issued with the queue already full");
                    spaceErrors++;
                end
                accCount++;
                memBusy = 1'b1;
                memAddr = icReqAddr_o;
                // wait of w gives a latency of w+1 cycles
                memWait = slowMem ? 2 + ($random(seed) & 1) : ($random(seed) & 3);
            end
            if (rst && outValid_o && outReady) begin
                gotQ.push_back(outBlock_o);
            end
        end
    end

    `include "fetchTests.svh"

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst           = 1'b0;
        excValid      = 1'b0;
        excPc         = '0;
        brFlush       = 1'b0;
        brTarget      = '0;
        btbUpdValid   = 1'b0;
        btbUpdPc      = '0;
        btbUpdTarget  = '0;
        readyMode     = 1'b0;
        slowMem       = 1'b0;
        checkSpace    = 1'b0;
        gotBase       = 0;
        accCount      = 0;
        accBase       = 0;
        reqCycles     = 0;
        reqBase       = 0;
        mismatchCount = 0;
        otherCount    = 0;
        spaceErrors   = 0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        sequentialFromReset();
        branchInSlotOne();
        branchInSlotThree();
        excBeatsBranch();
        misalignedRedirect();
        backPressure();
        $display("errors: %0d mismatches, %0d other failures", mismatchCount,
                 otherCount + spaceErrors);
        if (mismatchCount + otherCount + spaceErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the fetch tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
+incdir+sim
logic/fetchPkg.sv
logic/fetchPcGen.sv
logic/branchTargetBuffer.sv
logic/fetchQueue.sv
logic/fetchControl.sv
logic/fetchUnit.sv
sim/fetchUnit_tb.sv

/* run.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module fetchUnit_tb \
    --Mdir obj_dir \
    -o fetchUnit_sim \
    -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/fetchUnit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1
